// ==== hdl/daqCtrl_defines.svh ====
`ifndef DAQCTRL_DEFINES_SVH
`define DAQCTRL_DEFINES_SVH

// Power pulsing timing, in clock cycles
`define PWR_SETTLE 8
`define ACQ_WINDOW 6
`define RESETB_LEN 3

// Words per readout of one acquisition
`define READ_WORDS 4

// Chip word width
`define WORD_W 16

// Width of the acquisition count from the host
`define CYCLE_W 8

`endif

// ==== hdl/DaqPkg.sv ====
`include "daqCtrl_defines.svh"

package DaqPkg;

    typedef logic [`WORD_W-1:0]  daqWordT;
    typedef logic [`CYCLE_W-1:0] cycleCountT;

    // Chip pins driven by one controller
    typedef struct packed {
        logic pwrOnA;
        logic pwrOnD;
        logic pwrOnAdc;
        logic pwrOnDac;
        logic resetB;
        logic startAcq;
    } daqPinsT;

    // Controller status toward readout and host
    typedef struct packed {
        logic startReadout;
        logic onceEnd;
        logic allDone;
        logic usbStartStop;
    } daqStatusT;

    typedef enum logic [3:0] {
        AutoIdle, AutoReset, AutoSettle, AutoAcq, AutoReadout,
        AutoWaitEnd, AutoWaitTx, AutoOnceEnd, AutoDone
    } autoStateT;

    typedef enum logic [3:0] {
        SlaveIdle, SlaveReset, SlaveSettle, SlaveArmed, SlaveAcq,
        SlaveReadout, SlaveWaitEnd, SlaveWaitTx, SlaveOnceEnd, SlaveDone
    } slaveStateT;

    typedef enum logic [1:0] {
        RdIdle, RdRead, RdDrain
    } readStateT;

endpackage

// ==== hdl/AutoDaq.sv ====
`timescale 1ns/1ps
`include "daqCtrl_defines.svh"

module AutoDaq import DaqPkg::*; (
    input  logic       Clk,
    input  logic       rst,
    input  logic       Start,
    input  cycleCountT AcqCycles,
    input  logic       EndReadout,
    input  logic       DataTransmitDone,
    output daqPinsT    Pins,
    output daqStatusT  Status
);

    localparam int TimerW = 8;

    autoStateT         state;
    autoStateT         nextState;
    logic [TimerW-1:0] timer;
    cycleCountT        runCount;
    logic              lastRun;
    logic              powerOn;

    // Run count includes the acquisition now finishing
    assign lastRun = (cycleCountT'(runCount + 1'b1) >= AcqCycles);

    ////////////////////////////////////////////////////////////////////////////
    // Acquisition sequence
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        nextState = state;
        case (state)
            AutoIdle:    if (Start) nextState = AutoReset;
            AutoReset:   if (timer == TimerW'(`RESETB_LEN - 1)) nextState = AutoSettle;
            AutoSettle:  if (timer == TimerW'(`PWR_SETTLE - 1)) nextState = AutoAcq;
            AutoAcq:     if (timer == TimerW'(`ACQ_WINDOW - 1)) nextState = AutoReadout;
            AutoReadout: nextState = AutoWaitEnd;
            AutoWaitEnd: if (EndReadout) nextState = AutoWaitTx;
            AutoWaitTx:  if (DataTransmitDone) nextState = AutoOnceEnd;
            // Power is off here, next run settles again
            AutoOnceEnd: nextState = lastRun ? AutoDone : AutoSettle;
            AutoDone:    nextState = AutoIdle;
            default:     nextState = AutoIdle;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state    <= AutoIdle;
            timer    <= '0;
            runCount <= '0;
        end else begin
            state <= nextState;
            // Timer restarts on every state change
            timer <= (nextState != state) ? '0 : timer + 1'b1;
            if (state == AutoIdle) begin
                runCount <= '0;
            end else if (state == AutoOnceEnd) begin
                runCount <= runCount + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pin and status decode
    ////////////////////////////////////////////////////////////////////////////
    assign powerOn = state inside {AutoReset, AutoSettle, AutoAcq, AutoReadout,
                                   AutoWaitEnd, AutoWaitTx};

    assign Pins.pwrOnA   = powerOn;
    assign Pins.pwrOnD   = powerOn;
    assign Pins.pwrOnAdc = powerOn;
    assign Pins.pwrOnDac = powerOn;
    assign Pins.resetB   = (state != AutoReset);
    assign Pins.startAcq = (state == AutoAcq);

    assign Status.startReadout = (state == AutoReadout);
    assign Status.onceEnd      = (state == AutoOnceEnd);
    assign Status.allDone      = (state == AutoDone);
    assign Status.usbStartStop = !(state inside {AutoIdle, AutoDone});

    // No acquisition on an unpowered front end
    assert property (@(posedge Clk) disable iff (rst)
        Pins.startAcq |-> Pins.pwrOnA && Pins.pwrOnD && Pins.pwrOnAdc && Pins.pwrOnDac);

endmodule

// ==== hdl/SlaveDaq.sv ====
`timescale 1ns/1ps
`include "daqCtrl_defines.svh"

module SlaveDaq import DaqPkg::*; (
    input  logic       Clk,
    input  logic       rst,
    input  logic       Start,
    input  logic       SingleStart,
    input  cycleCountT AcqCycles,
    input  logic       EndReadout,
    input  logic       DataTransmitDone,
    output daqPinsT    Pins,
    output daqStatusT  Status
);

    localparam int TimerW = 8;

    slaveStateT        state;
    slaveStateT        nextState;
    logic [TimerW-1:0] timer;
    cycleCountT        trigCount;
    logic              lastTrig;
    logic              powerOn;

    assign lastTrig = (cycleCountT'(trigCount + 1'b1) >= AcqCycles);

    ////////////////////////////////////////////////////////////////////////////
    // Arm, then one acquisition per trigger
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        nextState = state;
        case (state)
            SlaveIdle:    if (Start) nextState = SlaveReset;
            SlaveReset:   if (timer == TimerW'(`RESETB_LEN - 1)) nextState = SlaveSettle;
            SlaveSettle:  if (timer == TimerW'(`PWR_SETTLE - 1)) nextState = SlaveArmed;
            // Triggers only count here, busy states drop them
            SlaveArmed:   if (SingleStart) nextState = SlaveAcq;
            SlaveAcq:     if (timer == TimerW'(`ACQ_WINDOW - 1)) nextState = SlaveReadout;
            SlaveReadout: nextState = SlaveWaitEnd;
            SlaveWaitEnd: if (EndReadout) nextState = SlaveWaitTx;
            SlaveWaitTx:  if (DataTransmitDone) nextState = SlaveOnceEnd;
            SlaveOnceEnd: nextState = lastTrig ? SlaveDone : SlaveArmed;
            SlaveDone:    nextState = SlaveIdle;
            default:      nextState = SlaveIdle;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state     <= SlaveIdle;
            timer     <= '0;
            trigCount <= '0;
        end else begin
            state <= nextState;
            timer <= (nextState != state) ? '0 : timer + 1'b1;
            if (state == SlaveIdle) begin
                trigCount <= '0;
            end else if (state == SlaveOnceEnd) begin
                trigCount <= trigCount + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pin and status decode
    ////////////////////////////////////////////////////////////////////////////
    // Power held for the whole armed period
    assign powerOn = !(state inside {SlaveIdle, SlaveDone});

    assign Pins.pwrOnA   = powerOn;
    assign Pins.pwrOnD   = powerOn;
    assign Pins.pwrOnAdc = powerOn;
    assign Pins.pwrOnDac = powerOn;
    assign Pins.resetB   = (state != SlaveReset);
    assign Pins.startAcq = (state == SlaveAcq);

    assign Status.startReadout = (state == SlaveReadout);
    assign Status.onceEnd      = (state == SlaveOnceEnd);
    assign Status.allDone      = (state == SlaveDone);
    assign Status.usbStartStop = powerOn;

    // Readout starts right after the window closes, only while armed
    assert property (@(posedge Clk) disable iff (rst)
        Status.startReadout |-> $past(Pins.startAcq) && !Pins.startAcq
                                && Status.usbStartStop);

endmodule

// ==== hdl/DaqSwitcher.sv ====
`timescale 1ns/1ps

module DaqSwitcher import DaqPkg::*; (
    input  logic      Clk,
    input  logic      rst,
    input  logic      DaqSelect,
    input  daqPinsT   AutoPins,
    input  daqPinsT   SlavePins,
    input  daqStatusT AutoStatus,
    input  daqStatusT SlaveStatus,
    input  logic      UsbAcqStart,
    input  logic      EndReadout,
    input  logic      DataTransmitDone,
    input  logic      ExternalTrigger,
    output daqPinsT   Pins,
    output daqStatusT Status,
    output logic      AutoStart,
    output logic      SlaveStart,
    output logic      AutoEndReadout,
    output logic      SlaveEndReadout,
    output logic      AutoTransmitDone,
    output logic      SlaveTransmitDone,
    output logic      SingleStart,
    output logic      ActiveSelect
);

    // Zero selects AutoDaq
    logic activeSel;
    logic bothIdle;

    // A start in flight also blocks the swap
    assign bothIdle = !AutoStatus.usbStartStop && !SlaveStatus.usbStartStop && !UsbAcqStart;

    always_ff @(posedge Clk) begin
        if (rst) begin
            activeSel <= 1'b0;
        end else if (bothIdle) begin
            activeSel <= DaqSelect;
        end
    end

    assign ActiveSelect = activeSel;

    ////////////////////////////////////////////////////////////////////////////
    // Outward mux and event steering
    ////////////////////////////////////////////////////////////////////////////
    assign Pins   = activeSel ? SlavePins : AutoPins;
    assign Status = activeSel ? SlaveStatus : AutoStatus;

    assign AutoStart         = !activeSel && UsbAcqStart;
    assign SlaveStart        = activeSel && UsbAcqStart;
    assign AutoEndReadout    = !activeSel && EndReadout;
    assign SlaveEndReadout   = activeSel && EndReadout;
    assign AutoTransmitDone  = !activeSel && DataTransmitDone;
    assign SlaveTransmitDone = activeSel && DataTransmitDone;
    assign SingleStart       = activeSel && ExternalTrigger;

    // Unselected side stays idle, so no start ever reached it
    assert property (@(posedge Clk) disable iff (rst)
        activeSel |-> !AutoStatus.usbStartStop);

    assert property (@(posedge Clk) disable iff (rst)
        !activeSel |-> !SlaveStatus.usbStartStop);

endmodule

// ==== hdl/ReadoutCtrl.sv ====
`timescale 1ns/1ps
`include "daqCtrl_defines.svh"

module ReadoutCtrl import DaqPkg::*; (
    input  logic    Clk,
    input  logic    rst,
    input  logic    StartReadout,
    output logic    ChipRead,
    input  daqWordT ChipData,
    output logic    OutValid,
    output daqWordT OutData,
    input  logic    OutReady,
    output logic    EndReadout,
    output logic    DataTransmitDone
);

    localparam int CountW = $clog2(`READ_WORDS + 1);

    readStateT         state;
    logic [CountW-1:0] wordCount;
    logic              readPending;
    logic              lastCapture;
    logic              outLast;
    logic              transfer;
    logic              stageFree;

    assign transfer  = OutValid && OutReady;
    assign stageFree = !OutValid || OutReady;

    // One read in flight at most, so the landing word always finds the stage empty
    assign ChipRead = (state == RdRead) && !readPending && stageFree
                      && (wordCount != CountW'(`READ_WORDS));

    assign lastCapture = readPending && (wordCount == CountW'(`READ_WORDS));

    always_ff @(posedge Clk) begin
        if (rst) begin
            state            <= RdIdle;
            wordCount        <= '0;
            readPending      <= 1'b0;
            OutValid         <= 1'b0;
            outLast          <= 1'b0;
            EndReadout       <= 1'b0;
            DataTransmitDone <= 1'b0;
        end else begin
            readPending      <= ChipRead;
            EndReadout       <= lastCapture;
            DataTransmitDone <= transfer && outLast;

            if (ChipRead) begin
                wordCount <= wordCount + 1'b1;
            end

            // Output stage
            if (readPending) begin
                OutValid <= 1'b1;
                outLast  <= lastCapture;
            end else if (transfer) begin
                OutValid <= 1'b0;
            end

            case (state)
                RdIdle: begin
                    if (StartReadout) begin
                        state     <= RdRead;
                        wordCount <= '0;
                    end
                end
                RdRead:  if (lastCapture) state <= RdDrain;
                RdDrain: if (transfer && outLast) state <= RdIdle;
                default: state <= RdIdle;
            endcase
        end
    end

    // Chip word lands one cycle after ChipRead
    always_ff @(posedge Clk) begin
        if (readPending) begin
            OutData <= ChipData;
        end
    end

    assert property (@(posedge Clk) disable iff (rst)
        OutValid && !OutReady |=> OutValid && $stable(OutData));

endmodule

// ==== hdl/DaqTop.sv ====
`timescale 1ns/1ps

module DaqTop import DaqPkg::*; (
    input  logic       Clk,
    input  logic       rst,
    input  logic       DaqSelect,
    input  logic       UsbAcqStart,
    input  logic       ExternalTrigger,
    input  cycleCountT AcqCycles,
    input  daqWordT    ChipData,
    input  logic       OutReady,
    output daqPinsT    Pins,
    output daqStatusT  Status,
    output logic       ActiveSelect,
    output logic       ChipRead,
    output logic       OutValid,
    output daqWordT    OutData
);

    daqPinsT   autoPins;
    daqPinsT   slavePins;
    daqStatusT autoStatus;
    daqStatusT slaveStatus;
    logic      autoStart;
    logic      slaveStart;
    logic      autoEndReadout;
    logic      slaveEndReadout;
    logic      autoTransmitDone;
    logic      slaveTransmitDone;
    logic      singleStart;
    logic      endReadout;
    logic      dataTransmitDone;

    AutoDaq autoDaq (
        .Clk(Clk), .rst(rst), .Start(autoStart), .AcqCycles(AcqCycles),
        .EndReadout(autoEndReadout), .DataTransmitDone(autoTransmitDone),
        .Pins(autoPins), .Status(autoStatus)
    );

    SlaveDaq slaveDaq (
        .Clk(Clk), .rst(rst), .Start(slaveStart), .SingleStart(singleStart),
        .AcqCycles(AcqCycles), .EndReadout(slaveEndReadout),
        .DataTransmitDone(slaveTransmitDone), .Pins(slavePins), .Status(slaveStatus)
    );

    DaqSwitcher daqSwitcher (
        .Clk(Clk), .rst(rst), .DaqSelect(DaqSelect),
        .AutoPins(autoPins), .SlavePins(slavePins),
        .AutoStatus(autoStatus), .SlaveStatus(slaveStatus),
        .UsbAcqStart(UsbAcqStart), .EndReadout(endReadout),
        .DataTransmitDone(dataTransmitDone), .ExternalTrigger(ExternalTrigger),
        .Pins(Pins), .Status(Status),
        .AutoStart(autoStart), .SlaveStart(slaveStart),
        .AutoEndReadout(autoEndReadout), .SlaveEndReadout(slaveEndReadout),
        .AutoTransmitDone(autoTransmitDone), .SlaveTransmitDone(slaveTransmitDone),
        .SingleStart(singleStart), .ActiveSelect(ActiveSelect)
    );

    ReadoutCtrl readoutCtrl (
        .Clk(Clk), .rst(rst), .StartReadout(Status.startReadout),
        .ChipRead(ChipRead), .ChipData(ChipData),
        .OutValid(OutValid), .OutData(OutData), .OutReady(OutReady),
        .EndReadout(endReadout), .DataTransmitDone(dataTransmitDone)
    );

endmodule

// ==== verification/DaqTopTb.sv ====
`timescale 1ns/1ps
`include "daqCtrl_defines.svh"

module DaqTopTb import DaqPkg::*;;

    // Power lines off, RESET_B released, START_ACQ low
    localparam daqPinsT IdlePins = 6'b000010;

    logic       Clk;
    logic       rst;
    logic       DaqSelect;
    logic       UsbAcqStart;
    logic       ExternalTrigger;
    cycleCountT AcqCycles;
    daqWordT    ChipData = '0;
    logic       OutReady = 1'b0;
    daqPinsT    Pins;
    daqStatusT  Status;
    logic       ActiveSelect;
    logic       ChipRead;
    logic       OutValid;
    daqWordT    OutData;

    logic [31:0] lfsrState = 32'h26e4;
    daqWordT     readCount;
    daqWordT     expectedWord;
    logic        started;
    logic        trigSent;
    logic        prevStartAcq;
    logic        slaveArmed;
    int          errCount = 0;
    int          timeoutCount = 0;
    int          runsStarted = 0;
    int          doneCount;
    int          onceCount;
    int          acqCount;
    int          wordsInAcq;
    int          wordsTotal;

    DaqTop uut (.*);

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // 32 bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // One LFSR bit per cycle for the sink's ready
    always @(negedge Clk) begin
        lfsrState = lfsrNext(lfsrState);
        OutReady <= lfsrState[0];
    end

    // Chip model, a counter that advances on each read
    always @(posedge Clk) begin
        if (rst) begin
            readCount <= '0;
        end else if (ChipRead) begin
            readCount <= readCount + 1'b1;
        end
    end

    always @(negedge Clk) begin
        ChipData <= readCount;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard of words and acquisition pulses
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge Clk) begin
        if (rst) begin
            expectedWord <= 16'h0001;
            prevStartAcq <= 1'b0;
            slaveArmed   <= 1'b0;
            doneCount    <= 0;
            onceCount    <= 0;
            acqCount     <= 0;
            wordsInAcq   <= 0;
            wordsTotal   <= 0;
        end else begin
            prevStartAcq <= Pins.startAcq;
            // Slave run armed from its start pulse until allDone
            if (ActiveSelect && UsbAcqStart) begin
                slaveArmed <= 1'b1;
            end else if (Status.allDone) begin
                slaveArmed <= 1'b0;
            end
            if (Pins.startAcq && !prevStartAcq) begin
                acqCount <= acqCount + 1;
            end
            if (OutValid && OutReady) begin
                assert (OutData == expectedWord) else begin
                    errCount++;
                    $display("ERROR OutData got 0x%h expected 0x%h", OutData, expectedWord);
                end
                expectedWord <= expectedWord + 1'b1;
                wordsInAcq   <= wordsInAcq + 1;
                wordsTotal   <= wordsTotal + 1;
            end
            if (Status.onceEnd) begin
                assert (wordsInAcq == `READ_WORDS) else begin
                    errCount++;
                    $display("ERROR wordsInAcq got 0x%h expected 0x%h", wordsInAcq,
                             `READ_WORDS);
                end
                // Exactly one acquisition window per onceEnd
                assert (acqCount == onceCount + 1) else begin
                    errCount++;
                    $display("ERROR acqCount got 0x%h expected 0x%h", acqCount,
                             onceCount + 1);
                end
                onceCount  <= onceCount + 1;
                wordsInAcq <= 0;
            end
            if (Status.allDone) begin
                assert (onceCount == int'(AcqCycles)) else begin
                    errCount++;
                    $display("ERROR onceCount got 0x%h expected 0x%h", onceCount, AcqCycles);
                end
                doneCount <= doneCount + 1;
                onceCount <= 0;
                acqCount  <= 0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Protocol properties
    ////////////////////////////////////////////////////////////////////////////
    assert property (@(posedge Clk) disable iff (rst)
        !started |-> Pins == IdlePins && !OutValid && !ActiveSelect)
        else begin
            errCount++;
            $display("ERROR Pins got 0x%h expected 0x%h (OutValid 0x%h ActiveSelect 0x%h)",
                     Pins, IdlePins, OutValid, ActiveSelect);
        end

    assert property (@(posedge Clk) disable iff (rst)
        Pins.startAcq |-> Pins[5:2] == 4'hf)
        else begin
            errCount++;
            $display("ERROR Pins got 0x%h with startAcq high and power not full", Pins);
        end

    // AutoDaq turns power off between runs
    assert property (@(posedge Clk) disable iff (rst)
        !ActiveSelect && Status.onceEnd |-> Pins[5:2] == 4'h0)
        else begin
            errCount++;
            $display("ERROR Pins got 0x%h expected power off at onceEnd", Pins);
        end

    assert property (@(posedge Clk) disable iff (rst)
        slaveArmed && !Status.allDone |-> Pins[5:2] == 4'hf)
        else begin
            errCount++;
            $display("ERROR Pins got 0x%h expected power on while armed", Pins);
        end

    // Readout pulse right after the acquisition window
    assert property (@(posedge Clk) disable iff (rst)
        Status.startReadout |-> $past(Pins.startAcq) && !Pins.startAcq)
        else begin
            errCount++;
            $display("Readout started without a closing acquisition window before it");
        end

    assert property (@(posedge Clk) disable iff (rst)
        ChipRead |-> !OutValid || OutReady)
        else begin
            errCount++;
            $display("Chip read issued while the output stage was full and stalled");
        end

    assert property (@(posedge Clk) disable iff (rst)
        ActiveSelect && !trigSent |-> !Pins.startAcq)
        else begin
            errCount++;
            $display("START_ACQ rose in slave mode before any external trigger");
        end

    assert property (@(posedge Clk) disable iff (rst)
        ActiveSelect && $rose(Pins.startAcq) |-> $past(ExternalTrigger))
        else begin
            errCount++;
            $display("Slave acquisition started without a trigger in the cycle before");
        end

    assert property (@(posedge Clk) disable iff (rst)
        OutValid && !OutReady |=> OutValid && $stable(OutData))
        else begin
            errCount++;
            $display("ERROR OutData got 0x%h after a stall, word was not held", OutData);
        end

    assert property (@(posedge Clk) disable iff (rst)
        Status.usbStartStop |=> $stable(ActiveSelect))
        else begin
            errCount++;
            $display("ERROR ActiveSelect got 0x%h, changed during a run", ActiveSelect);
        end

    assert property (@(posedge Clk) disable iff (rst)
        !Status.usbStartStop && !UsbAcqStart |=> ActiveSelect == $past(DaqSelect))
        else begin
            errCount++;
            $display("ERROR ActiveSelect got 0x%h expected 0x%h", ActiveSelect,
                     $past(DaqSelect));
        end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic startRun(input cycleCountT count);
        AcqCycles = count;
        @(negedge Clk);
        UsbAcqStart = 1'b1;
        started     = 1'b1;
        runsStarted++;
        @(negedge Clk);
        UsbAcqStart = 1'b0;
    endtask

    task automatic waitAllDone(input int maxCycles);
        int startDone;
        int cycles;
        startDone = doneCount;
        cycles    = 0;
        while (doneCount == startDone && cycles < maxCycles) begin
            @(negedge Clk);
            cycles++;
        end
        if (doneCount == startDone) begin
            timeoutCount++;
            $display("Timeout: no allDone pulse within %0d cycles", maxCycles);
        end
    endtask

    // Trigger every tenth cycle, some land on a busy acquisition
    task automatic runTriggers(input int maxCycles);
        int startDone;
        int cycles;
        startDone = doneCount;
        cycles    = 0;
        while (doneCount == startDone && cycles < maxCycles) begin
            ExternalTrigger = (cycles % 10 == 0);
            if (ExternalTrigger) begin
                trigSent = 1'b1;
            end
            @(negedge Clk);
            cycles++;
        end
        ExternalTrigger = 1'b0;
        if (doneCount == startDone) begin
            timeoutCount++;
            $display("Timeout: slave run did not finish within %0d cycles", maxCycles);
        end
    endtask

    task automatic waitSelect(input logic value, input int maxCycles);
        int cycles;
        cycles = 0;
        while (ActiveSelect != value && cycles < maxCycles) begin
            @(negedge Clk);
            cycles++;
        end
        if (ActiveSelect != value) begin
            timeoutCount++;
            $display("Timeout: selection did not switch within %0d cycles", maxCycles);
        end
    endtask

    initial begin
        rst             = 1'b1;
        DaqSelect       = 1'b0;
        UsbAcqStart     = 1'b0;
        ExternalTrigger = 1'b0;
        AcqCycles       = '0;
        started         = 1'b0;
        trigSent        = 1'b0;
        repeat (3) @(negedge Clk);
        rst = 1'b0;
        repeat (12) @(negedge Clk);

        // AutoDaq series, selection change mid run
        startRun(8'd3);
        repeat (20) @(negedge Clk);
        DaqSelect = 1'b1;
        waitAllDone(3000);
        waitSelect(1'b1, 20);

        // SlaveDaq, armed but untriggered for a while
        startRun(8'd2);
        repeat (30) @(negedge Clk);
        DaqSelect = 1'b0;
        runTriggers(3000);
        waitSelect(1'b0, 20);

        startRun(8'd1);
        waitAllDone(1000);
        repeat (5) @(negedge Clk);

        $display("Closing counts: %0d check errors, %0d timeouts, %0d words, %0d of %0d runs",
                 errCount, timeoutCount, wordsTotal, doneCount, runsStarted);
        if (errCount == 0 && timeoutCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/DaqPkg.sv
hdl/AutoDaq.sv
hdl/SlaveDaq.sv
hdl/DaqSwitcher.sv
hdl/ReadoutCtrl.sv
hdl/DaqTop.sv
verification/DaqTopTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the DaqTop testbench with Verilator and runs it.
# Exit status is zero only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f sources.f --top-module DaqTopTb \
    -Mdir obj_dir -o DaqTopTbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/DaqTopTbSim)
simStatus=$?
echo "$output"

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
